// File: sampler_pkg.sv
package sampler_pkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    localparam int ADDR_W   = 12;   // Sample memory address
    localparam int SAMPLE_W = 16;   // Signed sample and mixed frame
    localparam int KEY_W    = 7;    // MIDI key number
    localparam int CNT_W    = 16;   // Sample period counter
    localparam int VOICE_W  = 4;    // Voice select on the setup port

    //////////////////////////////////////////////////
    // Default sizes for the top level
    //////////////////////////////////////////////////

    localparam int DEF_NUM_VOICES    = 4;
    localparam int DEF_BASE_KEY      = 36;    // C1, first drum key
    localparam int DEF_SAMPLE_PERIOD = 16;    // Clock cycles per audio sample
    localparam int DEF_DEPTH         = 4096;  // Words of sample memory

    //////////////////////////////////////////////////
    // Voice state
    //////////////////////////////////////////////////

    // A voice sits in SETUP until its region is fixed, then toggles
    // between silent and playing
    typedef enum logic [1:0] {
        SETUP,      // Region not yet fixed
        NOTE_OFF,   // Silent, waiting for a trigger
        NOTE_ON     // Stepping through the region
    } voice_state_t;

endpackage

// File: mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if
    import sampler_pkg::*;
();

    logic [ADDR_W-1:0]          addr;          // Held while valid is high
    logic                       valid;
    logic                       ready;         // High in the grant cycle
    logic signed [SAMPLE_W-1:0] sample;        // Read result
    logic                       sample_valid;  // One cycle after the grant

    modport voice (
        output addr,
        output valid,
        input  ready,
        input  sample,
        input  sample_valid
    );

    modport arb (
        input  addr,
        input  valid,
        output ready,
        output sample,
        output sample_valid
    );

endinterface

// File: sample_clock.sv
`timescale 1ns/1ps

module sample_clock
    import sampler_pkg::*;
#(
    parameter int SAMPLE_PERIOD = DEF_SAMPLE_PERIOD
) (
    input  logic             clk,
    input  logic             rst,
    output logic [CNT_W-1:0] count,
    output logic             period_start
);

    logic last_cycle;

    assign last_cycle = (count == CNT_W'(SAMPLE_PERIOD - 1));

    // Free running, wraps at the end of every audio period
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (last_cycle) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(1);
        end
    end

    // Shared by all voices and the mixer
    assign period_start = (count == '0);

endmodule

// File: instrument.sv
`timescale 1ns/1ps

module instrument
    import sampler_pkg::*;
#(
    parameter logic [KEY_W-1:0]   MIDI_KEY = KEY_W'(DEF_BASE_KEY),
    parameter logic [VOICE_W-1:0] VOICE_ID = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               period_start,
    input  logic               note_on,
    input  logic [KEY_W-1:0]   note_key,
    input  logic               setup_we,
    input  logic [VOICE_W-1:0] setup_voice,
    input  logic [ADDR_W-1:0]  setup_start,
    input  logic [ADDR_W-1:0]  setup_stop,
    input  logic               setup_complete,
    mem_req_if.voice           req
);

    voice_state_t      state;
    logic [ADDR_W-1:0] start_q;
    logic [ADDR_W-1:0] stop_q;      // Exclusive
    logic              trig_pend;   // Trigger waiting for the period start
    logic              hit;
    logic              last_addr;
    logic              load_start;
    logic              step;
    logic              finish;

    assign hit       = note_on && (note_key == MIDI_KEY) && (state != SETUP);
    assign last_addr = (req.addr == stop_q - ADDR_W'(1));

    //////////////////////////////////////////////////
    // Period start decisions
    //////////////////////////////////////////////////

    assign load_start = period_start && (hit || trig_pend);  // New note or retrigger
    assign step       = period_start && (state == NOTE_ON) && !load_start && !last_addr;
    assign finish     = period_start && (state == NOTE_ON) && !load_start && last_addr;

    // Region bounds, open only during setup
    always_ff @(posedge clk) begin
        if ((state == SETUP) && setup_we && (setup_voice == VOICE_ID)) begin
            start_q <= setup_start;
            stop_q  <= setup_stop;
        end
    end

    // Request address, only moves while valid is low
    always_ff @(posedge clk) begin
        if (load_start) begin
            req.addr <= start_q;
        end else if (step) begin
            req.addr <= req.addr + ADDR_W'(1);
        end
    end

    //////////////////////////////////////////////////
    // Voice FSM and request valid
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SETUP;
            trig_pend <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            if (req.valid && req.ready) begin
                req.valid <= 1'b0;        // Taken by the arbiter
            end

            if (period_start) begin
                trig_pend <= 1'b0;
            end else if (hit) begin
                trig_pend <= 1'b1;        // Keep it until the next period
            end

            case (state)
                SETUP: begin
                    if (setup_complete) begin
                        state <= NOTE_OFF;
                    end
                end
                NOTE_OFF, NOTE_ON: begin
                    if (load_start) begin
                        state     <= NOTE_ON;
                        req.valid <= 1'b1;
                    end else if (step) begin
                        req.valid <= 1'b1;
                    end else if (finish) begin
                        state <= NOTE_OFF;  // stop-1 was served last period
                    end
                end
                default: begin
                    state <= SETUP;
                end
            endcase
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import sampler_pkg::*;
#(
    parameter int NUM_VOICES = DEF_NUM_VOICES
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [SAMPLE_W-1:0]        rd_data,
    mem_req_if.arb                     req [NUM_VOICES],
    output logic [ADDR_W-1:0]          rd_addr,
    output logic signed [SAMPLE_W-1:0] mix_sample [NUM_VOICES],
    output logic [NUM_VOICES-1:0]      mix_valid
);

    localparam int IDX_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1;

    logic [NUM_VOICES-1:0] req_valid;
    logic [ADDR_W-1:0]     req_addr [NUM_VOICES];
    logic [IDX_W-1:0]      ptr;       // Highest priority voice
    logic [IDX_W-1:0]      gnt_idx;
    logic                  gnt_any;
    logic                  rd_pend;   // Read in flight in the memory
    logic [IDX_W-1:0]      rd_idx;    // Owner of that read

    //////////////////////////////////////////////////
    // Per voice wiring
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
        assign req_valid[i]        = req[i].valid;
        assign req_addr[i]         = req[i].addr;
        assign req[i].ready        = gnt_any && (gnt_idx == IDX_W'(i));
        assign mix_valid[i]        = rd_pend && (rd_idx == IDX_W'(i));
        assign mix_sample[i]       = rd_data;       // Qualified by mix_valid
        assign req[i].sample       = rd_data;
        assign req[i].sample_valid = mix_valid[i];
    end

    // First requester at or after ptr, wrapping
    always_comb begin
        int cand;
        gnt_any = 1'b0;
        gnt_idx = '0;
        for (int k = 0; k < NUM_VOICES; k++) begin
            cand = (int'(ptr) + k) % NUM_VOICES;
            if (!gnt_any && req_valid[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = IDX_W'(cand);
            end
        end
    end

    assign rd_addr = req_addr[gnt_idx];

    // Rotate priority past the voice just served
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr     <= '0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= gnt_any;
            if (gnt_any) begin
                ptr <= (gnt_idx == IDX_W'(NUM_VOICES - 1)) ? '0 : gnt_idx + IDX_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_idx <= gnt_idx;    // Matches the memory's read latency
    end

endmodule

// File: sample_rom.sv
`timescale 1ns/1ps

module sample_rom
    import sampler_pkg::*;
#(
    parameter int DEPTH = DEF_DEPTH
) (
    input  logic                clk,
    input  logic                we,
    input  logic [ADDR_W-1:0]   waddr,
    input  logic [SAMPLE_W-1:0] wdata,
    input  logic [ADDR_W-1:0]   raddr,
    output logic [SAMPLE_W-1:0] rdata
);

    logic [SAMPLE_W-1:0] mem [DEPTH];

    // Load port, used before setup completes
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: sample_mixer.sv
`timescale 1ns/1ps

module sample_mixer
    import sampler_pkg::*;
#(
    parameter int NUM_VOICES = DEF_NUM_VOICES
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       period_start,
    input  logic signed [SAMPLE_W-1:0] mix_sample [NUM_VOICES],
    input  logic [NUM_VOICES-1:0]      mix_valid,
    input  logic                       audio_ready,
    output logic signed [SAMPLE_W-1:0] audio_data,
    output logic                       audio_valid,
    output logic                       overrun
);

    // Room for every voice at full scale
    localparam int ACC_W = SAMPLE_W + $clog2(NUM_VOICES + 1) + 1;
    localparam logic signed [ACC_W-1:0] ACC_MAX = ACC_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [ACC_W-1:0] ACC_MIN = -ACC_MAX - ACC_W'(1);

    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] cyc_sum;   // Samples arriving this cycle
    logic signed [ACC_W-1:0] total;
    logic signed [SAMPLE_W-1:0] clamped;

    always_comb begin
        cyc_sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (mix_valid[i]) begin
                cyc_sum = cyc_sum + ACC_W'(mix_sample[i]);   // Sign extended
            end
        end
    end

    assign total = acc + cyc_sum;

    // Clamp to the signed sample range
    always_comb begin
        if (total > ACC_MAX) begin
            clamped = SAMPLE_W'(ACC_MAX);
        end else if (total < ACC_MIN) begin
            clamped = SAMPLE_W'(ACC_MIN);
        end else begin
            clamped = SAMPLE_W'(total);
        end
    end

    //////////////////////////////////////////////////
    // Accumulator and output handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            acc         <= '0;
            audio_valid <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            if (audio_valid && audio_ready) begin
                audio_valid <= 1'b0;
            end
            if (period_start) begin
                acc         <= '0;
                audio_valid <= 1'b1;
                if (audio_valid && !audio_ready) begin
                    overrun <= 1'b1;   // Held frame is dropped
                end
            end else begin
                acc <= total;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (period_start) begin
            audio_data <= clamped;
        end
    end

endmodule

// File: sampler_top.sv
`timescale 1ns/1ps

module sampler_top
    import sampler_pkg::*;
#(
    parameter int NUM_VOICES    = DEF_NUM_VOICES,
    parameter int BASE_KEY      = DEF_BASE_KEY,
    parameter int SAMPLE_PERIOD = DEF_SAMPLE_PERIOD,
    parameter int DEPTH         = DEF_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    // Region setup
    input  logic                       setup_we,
    input  logic [VOICE_W-1:0]         setup_voice,
    input  logic [ADDR_W-1:0]          setup_start,
    input  logic [ADDR_W-1:0]          setup_stop,      // Exclusive
    input  logic                       setup_complete,
    // Sample memory load
    input  logic                       mem_we,
    input  logic [ADDR_W-1:0]          mem_addr,
    input  logic [SAMPLE_W-1:0]        mem_data,
    // Decoded MIDI
    input  logic                       note_on,
    input  logic [KEY_W-1:0]           note_key,
    // Audio frames
    output logic signed [SAMPLE_W-1:0] audio_data,
    output logic                       audio_valid,
    input  logic                       audio_ready,
    output logic                       overrun
);

    logic                       period_start;
    logic [ADDR_W-1:0]          rd_addr;
    logic [SAMPLE_W-1:0]        rd_data;
    logic signed [SAMPLE_W-1:0] mix_sample [NUM_VOICES];
    logic [NUM_VOICES-1:0]      mix_valid;

    mem_req_if u_req [NUM_VOICES] ();

    sample_clock #(
        .SAMPLE_PERIOD (SAMPLE_PERIOD)
    ) u_sample_clock (
        .clk          (clk),
        .rst          (rst),
        .count        (),
        .period_start (period_start)
    );

    //////////////////////////////////////////////////
    // Voices, one key each starting at BASE_KEY
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_inst
        instrument #(
            .MIDI_KEY (KEY_W'(BASE_KEY + i)),
            .VOICE_ID (VOICE_W'(i))
        ) u_instrument (
            .clk            (clk),
            .rst            (rst),
            .period_start   (period_start),
            .note_on        (note_on),
            .note_key       (note_key),
            .setup_we       (setup_we),
            .setup_voice    (setup_voice),
            .setup_start    (setup_start),
            .setup_stop     (setup_stop),
            .setup_complete (setup_complete),
            .req            (u_req[i])
        );
    end

    mem_arbiter #(
        .NUM_VOICES (NUM_VOICES)
    ) u_mem_arbiter (
        .clk        (clk),
        .rst        (rst),
        .rd_data    (rd_data),
        .req        (u_req),
        .rd_addr    (rd_addr),
        .mix_sample (mix_sample),
        .mix_valid  (mix_valid)
    );

    sample_rom #(
        .DEPTH (DEPTH)
    ) u_sample_rom (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_addr),
        .wdata (mem_data),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    sample_mixer #(
        .NUM_VOICES (NUM_VOICES)
    ) u_sample_mixer (
        .clk          (clk),
        .rst          (rst),
        .period_start (period_start),
        .mix_sample   (mix_sample),
        .mix_valid    (mix_valid),
        .audio_ready  (audio_ready),
        .audio_data   (audio_data),
        .audio_valid  (audio_valid),
        .overrun      (overrun)
    );

endmodule

// File: tb_sampler.sv
`timescale 1ns/1ps

module tb_sampler
    import sampler_pkg::*;
();

    localparam int NUM_VOICES      = 4;
    localparam int BASE_KEY        = 36;
    localparam int SAMPLE_PERIOD   = 16;
    localparam int DEPTH           = 4096;
    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 * SAMPLE_PERIOD;
    localparam logic [31:0] SEED   = 32'h9ba4_ac7c;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       setup_we;
    logic [VOICE_W-1:0]         setup_voice;
    logic [ADDR_W-1:0]          setup_start;
    logic [ADDR_W-1:0]          setup_stop;
    logic                       setup_complete;
    logic                       mem_we;
    logic [ADDR_W-1:0]          mem_addr;
    logic [SAMPLE_W-1:0]        mem_data;
    logic                       note_on;
    logic [KEY_W-1:0]           note_key;
    logic signed [SAMPLE_W-1:0] audio_data;
    logic                       audio_valid;
    logic                       audio_ready;
    logic                       overrun;

    // Reference model state
    logic signed [SAMPLE_W-1:0] model_mem [DEPTH];
    logic [ADDR_W-1:0]          m_start [NUM_VOICES];
    logic [ADDR_W-1:0]          m_stop [NUM_VOICES];    // Exclusive
    logic [ADDR_W-1:0]          m_addr [NUM_VOICES];
    logic                       m_active [NUM_VOICES];
    logic                       m_req [NUM_VOICES];     // Address issued this period
    logic                       m_pend [NUM_VOICES];
    logic [CNT_W-1:0]           m_cnt;
    logic                       m_setup_done;
    logic signed [SAMPLE_W-1:0] exp_data;
    logic                       exp_valid;
    logic                       exp_overrun;

    int          err_cnt   = 0;
    int          err_mark  = 0;
    int          pass_cnt  = 0;
    int          fail_cnt  = 0;
    int          frame_cnt = 0;
    int          frame_mark = 0;
    logic [31:0] rng = SEED;

    always #50 clk = ~clk;

    sampler_top #(
        .NUM_VOICES    (NUM_VOICES),
        .BASE_KEY      (BASE_KEY),
        .SAMPLE_PERIOD (SAMPLE_PERIOD),
        .DEPTH         (DEPTH)
    ) u_sampler_top (
        .clk            (clk),
        .rst            (rst),
        .setup_we       (setup_we),
        .setup_voice    (setup_voice),
        .setup_start    (setup_start),
        .setup_stop     (setup_stop),
        .setup_complete (setup_complete),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .note_on        (note_on),
        .note_key       (note_key),
        .audio_data     (audio_data),
        .audio_valid    (audio_valid),
        .audio_ready    (audio_ready),
        .overrun        (overrun)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] clamp_sample(input int total);
        int hi;
        int lo;
        hi = (1 << (SAMPLE_W - 1)) - 1;
        lo = -hi - 1;
        if (total > hi) begin
            return SAMPLE_W'(hi);
        end else if (total < lo) begin
            return SAMPLE_W'(lo);
        end
        return SAMPLE_W'(total);
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    always @(posedge clk) begin : ref_model
        int   sum;
        logic ps;
        logic hit;
        if (rst) begin
            m_cnt        <= '0;
            m_setup_done <= 1'b0;
            exp_data     <= '0;
            exp_valid    <= 1'b0;
            exp_overrun  <= 1'b0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                m_active[v] <= 1'b0;
                m_req[v]    <= 1'b0;
                m_pend[v]   <= 1'b0;
            end
        end else begin
            ps    = (m_cnt == '0);
            m_cnt <= (m_cnt == CNT_W'(SAMPLE_PERIOD - 1)) ? '0 : m_cnt + CNT_W'(1);
            if (exp_valid && audio_ready) begin
                exp_valid <= 1'b0;
            end
            if (ps) begin
                sum = 0;
                for (int v = 0; v < NUM_VOICES; v++) begin
                    if (m_req[v]) begin
                        sum += int'(model_mem[m_addr[v]]);
                    end
                end
                exp_data  <= clamp_sample(sum);
                exp_valid <= 1'b1;
                if (exp_valid && !audio_ready) begin
                    exp_overrun <= 1'b1;   // Held frame replaced
                end
            end
            for (int v = 0; v < NUM_VOICES; v++) begin
                hit = note_on && (note_key == KEY_W'(BASE_KEY + v)) && m_setup_done;
                if (ps) begin
                    m_pend[v] <= 1'b0;
                    if (hit || m_pend[v]) begin
                        m_addr[v]   <= m_start[v];
                        m_req[v]    <= 1'b1;
                        m_active[v] <= 1'b1;
                    end else if (m_active[v] && (m_addr[v] != m_stop[v] - ADDR_W'(1))) begin
                        m_addr[v] <= m_addr[v] + ADDR_W'(1);
                        m_req[v]  <= 1'b1;
                    end else begin
                        m_active[v] <= 1'b0;
                        m_req[v]    <= 1'b0;
                    end
                end else if (hit) begin
                    m_pend[v] <= 1'b1;
                end
            end
            if (setup_complete) begin
                m_setup_done <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && audio_valid && audio_ready) begin
            frame_cnt <= frame_cnt + 1;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (rst) audio_valid == exp_valid)
        else begin
            err_cnt++;
            $display("[FAIL] %0t ns: audio_valid is %0b, expected %0b",
                     $time, $sampled(audio_valid), $sampled(exp_valid));
        end

    a_data: assert property (@(posedge clk) disable iff (rst)
                             audio_valid |-> (audio_data == exp_data))
        else begin
            err_cnt++;
            $display("[FAIL] %0t ns: frame is %0d, expected %0d",
                     $time, $sampled(audio_data), $sampled(exp_data));
        end

    a_overrun: assert property (@(posedge clk) disable iff (rst) overrun == exp_overrun)
        else begin
            err_cnt++;
            $display("[FAIL] %0t ns: overrun is %0b, expected %0b",
                     $time, $sampled(overrun), $sampled(exp_overrun));
        end

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [SAMPLE_W-1:0] data);
        @(negedge clk);
        mem_we          = 1'b1;
        mem_addr        = addr;
        mem_data        = data;
        model_mem[addr] = data;
    endtask

    task automatic set_region(input int v);
        @(negedge clk);
        setup_we    = 1'b1;
        setup_voice = VOICE_W'(v);
        setup_start = m_start[v];
        setup_stop  = m_stop[v];
    endtask

    task automatic play_note(input int key);
        @(negedge clk);
        note_on  = 1'b1;
        note_key = KEY_W'(key);
        @(negedge clk);
        note_on = 1'b0;
    endtask

    task automatic wait_periods(input int n);
        repeat (n * SAMPLE_PERIOD) @(negedge clk);
    endtask

    task automatic start_test();
        err_mark   = err_cnt;
        frame_mark = frame_cnt;
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("[PASS] %0t ns: %s", $time, name);
        end else begin
            fail_cnt++;
            $display("[FAIL] %0t ns: %s, %0d errors", $time, name, err_cnt - err_mark);
        end
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, "", 0);
        rst            = 1'b1;
        setup_we       = 1'b0;
        setup_voice    = '0;
        setup_start    = '0;
        setup_stop     = '0;
        setup_complete = 1'b0;
        mem_we         = 1'b0;
        mem_addr       = '0;
        mem_data       = '0;
        note_on        = 1'b0;
        note_key       = '0;
        audio_ready    = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Large words, sign follows the index so aligned voices clamp both ways
        for (int v = 0; v < NUM_VOICES; v++) begin
            m_start[v] = ADDR_W'(32 * v + 5);
            m_stop[v]  = ADDR_W'(32 * v + 11 + v);
            for (int j = 0; j < 6 + v; j++) begin
                rng = xorshift32(rng);
                load_word(m_start[v] + ADDR_W'(j), {j[1], ~j[1], rng[13:0]});
            end
        end
        @(negedge clk);
        mem_we = 1'b0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            set_region(v);
        end
        @(negedge clk);
        setup_we       = 1'b0;
        setup_complete = 1'b1;
        wait_periods(1);

        start_test();
        wait_periods(10);
        assert (frame_cnt - frame_mark == 10) else begin
            err_cnt++;
            $display("[FAIL] %0t ns: %0d frames in 10 periods", $time, frame_cnt - frame_mark);
        end
        finish_test("idle frames");

        start_test();
        play_note(BASE_KEY + 1);
        wait_periods(12);
        finish_test("single note");

        start_test();
        play_note(BASE_KEY + 7);   // No voice on this key
        wait_periods(6);
        finish_test("unmapped key");

        start_test();
        play_note(BASE_KEY + 3);
        wait_periods(4);
        play_note(BASE_KEY + 3);
        wait_periods(14);
        finish_test("retrigger");

        start_test();
        do @(negedge clk); while (m_cnt != CNT_W'(2));
        for (int v = 0; v < NUM_VOICES; v++) begin
            play_note(BASE_KEY + v);
        end
        wait_periods(13);
        finish_test("four voice mix");

        start_test();
        play_note(BASE_KEY);
        wait_periods(1);
        audio_ready = 1'b0;        // Blocks across two period starts
        wait_periods(2);
        audio_ready = 1'b1;
        wait_periods(8);
        assert (overrun) else begin
            err_cnt++;
            $display("[FAIL] %0t ns: overrun stayed low after a frame was held",
                     $time);
        end
        finish_test("back-pressure");

        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                 NUM_TESTS, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
sampler_pkg.sv
mem_req_if.sv
sample_clock.sv
instrument.sv
mem_arbiter.sv
sample_rom.sv
sample_mixer.sv
sampler_top.sv
tb_sampler.sv

// File: run_sim.sh
#!/bin/sh
# Builds the sampler testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -j 0 --timescale 1ns/1ps \
    --top-module tb_sampler -f filelist.f -o tb_sampler > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/tb_sampler > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -q "Test FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Test OK" "$SIM_LOG"; then
    echo "No verdict found in $SIM_LOG"
    exit 1
fi
exit 0
